// ==== hw/mioc_params.svh ====
// memory and I/O controller parameters
// bus widths, map port pattern and region bounds shared by the RTL and the package

`ifndef MIOC_PARAMS_SVH
`define MIOC_PARAMS_SVH

// high address bits BA15..BA13 as seen by the decoder
`define MIOC_ADDR_HI_W 3

// data nibble BD3..BD0 latched by an I/O write to the map port
`define MIOC_MAP_DATA_W 4

// one half of the map is two bits wide, two halves fill the nibble
`define MIOC_MAP_FIELD_W 2

// the map port answers when BA7 is low and BA6 is high
`define MIOC_MAP_PORT_A7 1'b0
`define MIOC_MAP_PORT_A6 1'b1

// the boot ROM covers 0000-5FFF, so codes 000 up to 010 of BA15..BA13
// codes 011 in the lower half fall through to the lower RAM bank
`define MIOC_BOOT_ROM_TOP 3'b010

`endif

// ==== hw/mioc_pkg.sv ====
// memory and I/O controller types
// map fields, the DRAM request and the DRAM sequencer states

`include "mioc_params.svh"

package mioc_pkg;

   // what answers in the lower 32K, from BD1..BD0
   typedef enum logic [`MIOC_MAP_FIELD_W-1:0] {
      LOW_BOOT = 2'd0,   // boot ROM up to 5FFF, lower RAM above it
      LOW_RAM  = 2'd1,   // lower RAM bank for the whole half
      LOW_EXP  = 2'd2,   // expansion ROM slot
      LOW_NONE = 2'd3    // nothing is selected
   } lower_map_t;

   // what answers in the upper 32K, from BD3..BD2
   typedef enum logic [`MIOC_MAP_FIELD_W-1:0] {
      UP_RAM   = 2'd0,   // upper RAM bank
      UP_NONE1 = 2'd1,   // unused code, nothing selected
      UP_NONE2 = 2'd2,   // unused code, nothing selected
      UP_CART  = 2'd3    // cartridge through the 245 buffer
   } upper_map_t;

   // the map nibble, upper field in the high bits as written on the data bus
   typedef struct packed {
      upper_map_t upper;   // BD3..BD2
      lower_map_t lower;   // BD1..BD0
   } map_reg_t;

   // request from the decoder to the DRAM sequencer
   typedef enum logic [1:0] {
      REQ_NONE    = 2'd0,   // no DRAM activity
      REQ_LOWER   = 2'd1,   // access to the lower bank, CAS1
      REQ_UPPER   = 2'd2,   // access to the upper bank, CAS2
      REQ_REFRESH = 2'd3    // RAS-only refresh
   } dram_req_t;

   // sequencer states, one per strobe step
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,   // all strobes inactive
      ST_ROW  = 2'd1,   // RAS low with the row address
      ST_MUX  = 2'd2,   // address mux switched to the column
      ST_COL  = 2'd3    // bank CAS low
   } dram_state_t;

endpackage

// ==== hw/bus_cycle_if.sv ====
// one sampled Z80 bus cycle, all strobes active high
// driven by the sampler and read by the map register and the decoder

`include "mioc_params.svh"

interface bus_cycle_if;

   logic                        mreq;       // memory request
   logic                        rd;         // read strobe
   logic                        wr;         // write strobe
   logic                        iorq;       // I/O request
   logic                        rfsh;       // refresh cycle in progress
   logic [`MIOC_ADDR_HI_W-1:0]  addr_hi;    // BA15..BA13
   logic                        port_a7;    // BA7 for the port decode
   logic                        port_a6;    // BA6 for the port decode
   logic [`MIOC_MAP_DATA_W-1:0] data;       // BD3..BD0
   logic                        pb_reset;   // push-button reset held down

   modport sampler (
      output mreq, rd, wr, iorq, rfsh, addr_hi, port_a7, port_a6, data, pb_reset
   );

   // the map register only looks at I/O writes and the reset button
   modport map_port (
      input iorq, rd, wr, port_a7, port_a6, data, pb_reset
   );

   modport decode (
      input mreq, rfsh, addr_hi
   );

endinterface

// ==== hw/bus_sampler.sv ====
// Z80 bus sampler
// registers the raw active-low pins once on b_phi and presents them as active-high strobes

module bus_sampler (
   input  logic b_phi,     // buffered Z80 clock
   input  logic rst,       // synchronous reset, active high
   input  logic ba15,      // address line 15
   input  logic ba14,      // address line 14
   input  logic ba13,      // address line 13
   input  logic ba7,       // address line 7
   input  logic ba6,       // address line 6
   input  logic bd0,       // data line 0
   input  logic bd1,       // data line 1
   input  logic bd2,       // data line 2
   input  logic bd3,       // data line 3
   input  logic iorq_n,    // I/O request
   input  logic bmreq_n,   // buffered memory request
   input  logic bwr_n,     // buffered write
   input  logic brd_n,     // buffered read
   input  logic brfsh_n,   // buffered refresh
   input  logic pbrst_n,   // push-button reset switch
   bus_cycle_if.sampler bus
);

   // strobes are control state and come out of reset inactive
   always_ff @(posedge b_phi) begin
      if (rst) begin
         bus.mreq     <= 1'b0;
         bus.rd       <= 1'b0;
         bus.wr       <= 1'b0;
         bus.iorq     <= 1'b0;
         bus.rfsh     <= 1'b0;
         bus.pb_reset <= 1'b0;
      end else begin
         bus.mreq     <= ~bmreq_n;   // pins are active low, the interface is active high
         bus.rd       <= ~brd_n;
         bus.wr       <= ~bwr_n;
         bus.iorq     <= ~iorq_n;
         bus.rfsh     <= ~brfsh_n;
         bus.pb_reset <= ~pbrst_n;   // the switch is sampled like any other strobe
      end
   end

   // address and data only matter while a strobe is up
   always_ff @(posedge b_phi) begin
      bus.addr_hi <= {ba15, ba14, ba13};   // ba15 ends up as the half select bit
      bus.port_a7 <= ba7;
      bus.port_a6 <= ba6;
      bus.data    <= {bd3, bd2, bd1, bd0};   // bd3..bd2 upper field, bd1..bd0 lower field
   end

endmodule

// ==== hw/memory_map_reg.sv ====
// memory map register
// latches BD3..BD0 on an I/O write to the map port, cleared by reset or the reset button

`include "mioc_params.svh"

module memory_map_reg (
   input  logic                b_phi,   // buffered Z80 clock
   input  logic                rst,     // synchronous reset, active high
   bus_cycle_if.map_port       bus,     // sampled bus cycle
   output mioc_pkg::map_reg_t  map      // current memory map
);

   logic port_hit;   // BA7/BA6 carry the map port pattern
   logic map_wr;     // sampled I/O write aimed at the map port

   assign port_hit = (bus.port_a7 == `MIOC_MAP_PORT_A7) &&
                     (bus.port_a6 == `MIOC_MAP_PORT_A6);

   // a cycle that shows rd and wr together is not a clean write and is ignored
   assign map_wr = bus.iorq && bus.wr && !bus.rd && port_hit;

   // map zero is boot ROM low and RAM high, the power-on layout
   always_ff @(posedge b_phi) begin
      if (rst || bus.pb_reset) begin
         map <= '0;
      end else if (map_wr) begin
         map <= mioc_pkg::map_reg_t'(bus.data);   // nibble splits straight into the two fields
      end
   end

   // the reset button wins over a write in the same cycle, the same as rst
   // the register holds its value for as long as no new write arrives
   // a write stays visible from the cycle after the sampled strobe

endmodule

// ==== hw/memory_decoder.sv ====
// address decoder
// turns the sampled address and the memory map into chip selects and a DRAM request

`include "mioc_params.svh"

module memory_decoder (
   bus_cycle_if.decode          bus,           // sampled bus cycle
   input  mioc_pkg::map_reg_t   map,           // current memory map
   output logic                 bootromcs_n,   // boot ROM chip select
   output logic                 auxromcs_n,    // expansion ROM chip select
   output logic                 en245_n,       // cartridge buffer enable
   output mioc_pkg::dram_req_t  dram_req       // request to the DRAM sequencer
);

   logic upper_half;   // BA15 set, so the upper 32K is addressed
   logic boot_area;    // address below 6000, where the boot ROM lives
   logic mem_cycle;    // normal memory access, refresh excluded
   logic rfsh_cycle;   // refresh with the memory request up

   assign upper_half = bus.addr_hi[`MIOC_ADDR_HI_W-1];
   assign boot_area  = (bus.addr_hi <= `MIOC_BOOT_ROM_TOP);
   assign mem_cycle  = bus.mreq && !bus.rfsh;
   assign rfsh_cycle = bus.mreq && bus.rfsh;

   // everything below reads registered inputs only, so the outputs are one cycle behind the pins
   always_comb begin
      bootromcs_n = 1'b1;
      auxromcs_n  = 1'b1;
      en245_n     = 1'b1;
      dram_req    = mioc_pkg::REQ_NONE;

      if (rfsh_cycle) begin
         dram_req = mioc_pkg::REQ_REFRESH;   // refresh address is not a real access, no select
      end else if (mem_cycle && !upper_half) begin
         case (map.lower)
            mioc_pkg::LOW_BOOT: begin
               if (boot_area) begin
                  bootromcs_n = 1'b0;
               end else begin
                  dram_req = mioc_pkg::REQ_LOWER;   // 6000-7FFF is RAM under the boot map
               end
            end
            mioc_pkg::LOW_RAM: begin
               dram_req = mioc_pkg::REQ_LOWER;
            end
            mioc_pkg::LOW_EXP: begin
               auxromcs_n = 1'b0;
            end
            default: begin
               // unmapped lower half, the bus floats
            end
         endcase
      end else if (mem_cycle) begin
         case (map.upper)
            mioc_pkg::UP_RAM: begin
               dram_req = mioc_pkg::REQ_UPPER;
            end
            mioc_pkg::UP_CART: begin
               en245_n = 1'b0;   // cartridge data comes in through the 245
            end
            default: begin
               // codes 1 and 2 leave the upper half empty
            end
         endcase
      end
   end

endmodule

// ==== hw/dram_sequencer.sv ====
// DRAM timing sequencer
// steps RAS, MUX and the bank CAS for memory cycles, RAS only for refresh

module dram_sequencer (
   input  logic                 b_phi,      // buffered Z80 clock
   input  logic                 rst,        // synchronous reset, active high
   input  mioc_pkg::dram_req_t  dram_req,   // request from the decoder
   output logic                 ras_n,      // row address strobe
   output logic                 mux,        // DRAM address mux, high selects the column
   output logic                 cas1_n,     // column strobe, lower bank
   output logic                 cas2_n      // column strobe, upper bank
);

   mioc_pkg::dram_state_t state_q;     // current step
   mioc_pkg::dram_state_t state_nxt;   // step after this edge
   mioc_pkg::dram_req_t   bank_q;      // request the running cycle started with
   mioc_pkg::dram_req_t   bank_nxt;    // bank after this edge
   logic                  req_lost;    // request dropped or changed under a running cycle

   assign req_lost = (dram_req != bank_q);

   // a changed request is treated as an end, the new one starts again from idle
   always_comb begin
      state_nxt = state_q;
      bank_nxt  = bank_q;
      case (state_q)
         mioc_pkg::ST_IDLE: begin
            if (dram_req != mioc_pkg::REQ_NONE) begin
               state_nxt = mioc_pkg::ST_ROW;
               bank_nxt  = dram_req;   // remembered until the cycle ends
            end
         end
         mioc_pkg::ST_ROW: begin
            if (req_lost) begin
               state_nxt = mioc_pkg::ST_IDLE;
            end else if (bank_q != mioc_pkg::REQ_REFRESH) begin
               state_nxt = mioc_pkg::ST_MUX;   // refresh parks here with RAS low
            end
         end
         mioc_pkg::ST_MUX: begin
            if (req_lost) begin
               state_nxt = mioc_pkg::ST_IDLE;
            end else begin
               state_nxt = mioc_pkg::ST_COL;
            end
         end
         default: begin
            if (req_lost) begin
               state_nxt = mioc_pkg::ST_IDLE;   // column held until the strobe goes away
            end
         end
      endcase
      if (state_nxt == mioc_pkg::ST_IDLE) begin
         bank_nxt = mioc_pkg::REQ_NONE;
      end
   end

   always_ff @(posedge b_phi) begin
      if (rst) begin
         state_q <= mioc_pkg::ST_IDLE;
         bank_q  <= mioc_pkg::REQ_NONE;
      end else begin
         state_q <= state_nxt;
         bank_q  <= bank_nxt;
      end
   end

   // strobes come from flops fed by the next state, so they change on the edge only
   always_ff @(posedge b_phi) begin
      if (rst) begin
         ras_n  <= 1'b1;
         mux    <= 1'b0;
         cas1_n <= 1'b1;
         cas2_n <= 1'b1;
      end else begin
         ras_n  <= (state_nxt == mioc_pkg::ST_IDLE);
         mux    <= (state_nxt == mioc_pkg::ST_MUX) || (state_nxt == mioc_pkg::ST_COL);
         cas1_n <= !((state_nxt == mioc_pkg::ST_COL) && (bank_nxt == mioc_pkg::REQ_LOWER));
         cas2_n <= !((state_nxt == mioc_pkg::ST_COL) && (bank_nxt == mioc_pkg::REQ_UPPER));
      end
   end

endmodule

// ==== hw/mioc_top.sv ====
// memory and I/O controller top level
// map register, address decoder and DRAM sequencer behind one bus sampler

module mioc_top (
   input  logic b_phi,         // buffered Z80 clock
   input  logic rst,           // synchronous reset, active high
   input  logic ba15,          // address line 15
   input  logic ba14,          // address line 14
   input  logic ba13,          // address line 13
   input  logic ba7,           // address line 7
   input  logic ba6,           // address line 6
   input  logic bd0,           // data line 0
   input  logic bd1,           // data line 1
   input  logic bd2,           // data line 2
   input  logic bd3,           // data line 3
   input  logic iorq_n,        // Z80 I/O request
   input  logic bmreq_n,       // buffered memory request
   input  logic bwr_n,         // buffered write
   input  logic brd_n,         // buffered read
   input  logic brfsh_n,       // buffered refresh
   input  logic pbrst_n,       // push-button reset, clears the map
   output logic bootromcs_n,   // boot ROM chip select
   output logic auxromcs_n,    // expansion ROM chip select
   output logic en245_n,       // cartridge buffer enable
   output logic ras_n,         // row address strobe
   output logic mux,           // DRAM address mux
   output logic cas1_n,        // column strobe, lower RAM bank
   output logic cas2_n         // column strobe, upper RAM bank
);

   mioc_pkg::map_reg_t  map;        // map register to the decoder
   mioc_pkg::dram_req_t dram_req;   // decoder to the sequencer

   bus_cycle_if bus_i ();   // the sampled cycle every block works from

   bus_sampler bus_sampler_i (
      .b_phi   (b_phi),
      .rst     (rst),
      .ba15    (ba15),
      .ba14    (ba14),
      .ba13    (ba13),
      .ba7     (ba7),
      .ba6     (ba6),
      .bd0     (bd0),
      .bd1     (bd1),
      .bd2     (bd2),
      .bd3     (bd3),
      .iorq_n  (iorq_n),
      .bmreq_n (bmreq_n),
      .bwr_n   (bwr_n),
      .brd_n   (brd_n),
      .brfsh_n (brfsh_n),
      .pbrst_n (pbrst_n),
      .bus     (bus_i.sampler)
   );

   memory_map_reg memory_map_reg_i (
      .b_phi (b_phi),
      .rst   (rst),
      .bus   (bus_i.map_port),
      .map   (map)
   );

   memory_decoder memory_decoder_i (
      .bus         (bus_i.decode),
      .map         (map),
      .bootromcs_n (bootromcs_n),
      .auxromcs_n  (auxromcs_n),
      .en245_n     (en245_n),
      .dram_req    (dram_req)
   );

   dram_sequencer dram_sequencer_i (
      .b_phi    (b_phi),
      .rst      (rst),
      .dram_req (dram_req),
      .ras_n    (ras_n),
      .mux      (mux),
      .cas1_n   (cas1_n),
      .cas2_n   (cas2_n)
   );

endmodule

// ==== tests/mioc_properties.sv ====
// bound checker for the memory and I/O controller
// shadows the map from the pins and checks the selects and the DRAM strobe timing

`include "mioc_params.svh"

module mioc_properties (
   input  logic b_phi,                                   // buffered Z80 clock
   input  logic rst,                                     // synchronous reset, active high
   input  logic ba15, ba14, ba13, ba7, ba6,              // address pins
   input  logic bd0, bd1, bd2, bd3,                      // data pins
   input  logic iorq_n, bmreq_n, bwr_n, brd_n, brfsh_n,  // Z80 strobes
   input  logic pbrst_n,                                 // push-button reset
   input  logic bootromcs_n, auxromcs_n, en245_n,        // chip selects
   input  logic ras_n, mux, cas1_n, cas2_n,              // DRAM strobes
   output logic err_seen                                 // some assertion has fired
);

   logic                        s_mreq;      // pin strobes one cycle late, as the DUT sees them
   logic                        s_rfsh;
   logic                        s_map_wr;    // I/O write to the map port seen on the pins
   logic                        s_pb;
   logic [`MIOC_ADDR_HI_W-1:0]  s_hi;
   logic [`MIOC_MAP_DATA_W-1:0] s_data;
   mioc_pkg::map_reg_t          shadow_map;  // expected contents of the map register
   mioc_pkg::dram_req_t         exp_req;     // request the decoder ought to make
   mioc_pkg::dram_req_t         prev_req;
   logic [2:0]                  exp_sel_n;   // boot, aux, cartridge in that order
   logic [1:0]                  exp_cas;     // cas1_n, cas2_n once the column is up
   logic                        req_start;
   logic                        ram_start;
   logic err_sel = 1'b0;
   logic err_ras = 1'b0;
   logic err_mux = 1'b0;
   logic err_cas = 1'b0;
   logic err_end = 1'b0;
   logic err_rfsh = 1'b0;
   logic err_one = 1'b0;
   logic err_rst = 1'b0;

   always_ff @(posedge b_phi) begin
      if (rst) begin
         s_mreq   <= 1'b0;
         s_rfsh   <= 1'b0;
         s_map_wr <= 1'b0;
         s_pb     <= 1'b0;
         prev_req <= mioc_pkg::REQ_NONE;
      end else begin
         s_mreq   <= !bmreq_n;
         s_rfsh   <= !brfsh_n;
         s_map_wr <= !iorq_n && !bwr_n && (ba7 == `MIOC_MAP_PORT_A7) && (ba6 == `MIOC_MAP_PORT_A6);
         s_pb     <= !pbrst_n;
         prev_req <= exp_req;
      end
      s_hi   <= {ba15, ba14, ba13};
      s_data <= {bd3, bd2, bd1, bd0};
   end

   // the map moves one cycle after the late write, so two after the pins
   always_ff @(posedge b_phi) begin
      if (rst || s_pb) shadow_map <= '0;
      else if (s_map_wr) shadow_map <= mioc_pkg::map_reg_t'(s_data);
   end

   always_comb begin
      exp_sel_n = 3'b111;
      exp_req   = mioc_pkg::REQ_NONE;
      if (s_mreq && s_rfsh) begin
         exp_req = mioc_pkg::REQ_REFRESH;                    // refresh selects nothing
      end else if (s_mreq && s_hi[`MIOC_ADDR_HI_W-1]) begin
         if (shadow_map.upper == mioc_pkg::UP_RAM) exp_req = mioc_pkg::REQ_UPPER;
         else if (shadow_map.upper == mioc_pkg::UP_CART) exp_sel_n = 3'b110;
      end else if (s_mreq) begin
         if (shadow_map.lower == mioc_pkg::LOW_BOOT && s_hi <= `MIOC_BOOT_ROM_TOP) begin
            exp_sel_n = 3'b011;                            // 0000-5FFF under the boot map
         end else if (shadow_map.lower inside {mioc_pkg::LOW_BOOT, mioc_pkg::LOW_RAM}) begin
            exp_req = mioc_pkg::REQ_LOWER;
         end else if (shadow_map.lower == mioc_pkg::LOW_EXP) begin
            exp_sel_n = 3'b101;
         end
      end
   end

   assign req_start = (exp_req != mioc_pkg::REQ_NONE) && (prev_req == mioc_pkg::REQ_NONE);
   assign ram_start = req_start && (exp_req != mioc_pkg::REQ_REFRESH);
   assign exp_cas   = (exp_req == mioc_pkg::REQ_LOWER) ? 2'b01 : 2'b10;
   assign err_seen  = err_sel || err_ras || err_mux || err_cas || err_end || err_rfsh ||
                      err_one || err_rst;

   chip_select: assert property (@(posedge b_phi) disable iff (rst)
      {bootromcs_n, auxromcs_n, en245_n} == exp_sel_n) else begin
      err_sel = 1'b1;
      $error("Fail chip_select: expected %b actual %b", $sampled(exp_sel_n),
             $sampled({bootromcs_n, auxromcs_n, en245_n}));
   end

   // row strobe one cycle after the request, the mux still on the row address
   ras_fall: assert property (@(posedge b_phi) disable iff (rst)
      $past(req_start) |-> {ras_n, mux} == 2'b00) else begin
      err_ras = 1'b1;
      $error("Fail ras_fall: expected 00 actual %b", $sampled({ras_n, mux}));
   end

   mux_rise: assert property (@(posedge b_phi) disable iff (rst)
      $past(ram_start, 2) |-> {mux, cas1_n, cas2_n} == 3'b111) else begin
      err_mux = 1'b1;
      $error("Fail mux_rise: expected 111 actual %b", $sampled({mux, cas1_n, cas2_n}));
   end

   cas_fall: assert property (@(posedge b_phi) disable iff (rst)
      $past(ram_start, 3) |-> {cas1_n, cas2_n} == exp_cas) else begin
      err_cas = 1'b1;
      $error("Fail cas_fall: expected %b actual %b", $sampled(exp_cas),
             $sampled({cas1_n, cas2_n}));
   end

   // with no request the strobes are idle one cycle later, which also covers the release
   strobe_release: assert property (@(posedge b_phi) disable iff (rst)
      $past(exp_req == mioc_pkg::REQ_NONE) |-> {ras_n, mux, cas1_n, cas2_n} == 4'b1011) else begin
      err_end = 1'b1;
      $error("Fail strobe_release: expected 1011 actual %b",
             $sampled({ras_n, mux, cas1_n, cas2_n}));
   end

   refresh_quiet: assert property (@(posedge b_phi) disable iff (rst)
      exp_req == mioc_pkg::REQ_REFRESH |-> {mux, cas1_n, cas2_n} == 3'b011) else begin
      err_rfsh = 1'b1;
      $error("Fail refresh_quiet: expected 011 actual %b", $sampled({mux, cas1_n, cas2_n}));
   end

   one_select: assert property (@(posedge b_phi) disable iff (rst)
      $onehot0({!bootromcs_n, !auxromcs_n, !en245_n, !cas1_n, !cas2_n})) else begin
      err_one = 1'b1;
      $error("Fail one_select: expected at most one low actual %b",
             $sampled({bootromcs_n, auxromcs_n, en245_n, cas1_n, cas2_n}));
   end

   reset_state: assert property (@(posedge b_phi) disable iff (rst)
      $past(rst) |-> {bootromcs_n, auxromcs_n, en245_n, ras_n, mux, cas1_n, cas2_n} ==
      7'b1111011) else begin
      err_rst = 1'b1;
      $error("Fail reset_state: expected 1111011 actual %b",
             $sampled({bootromcs_n, auxromcs_n, en245_n, ras_n, mux, cas1_n, cas2_n}));
   end

endmodule

bind mioc_top mioc_properties mioc_properties_i (.*, .err_seen());

// ==== tests/mioc_tb.sv ====
// testbench for the memory and I/O controller
// random map writes and memory cycles, checked by the bound property module

`include "mioc_params.svh"

module mioc_tb;

   logic b_phi;
   logic rst;
   logic ba15, ba14, ba13, ba7, ba6;              // address pins
   logic bd0, bd1, bd2, bd3;                      // data pins
   logic iorq_n, bmreq_n, bwr_n, brd_n, brfsh_n;  // Z80 strobes
   logic pbrst_n;
   logic bootromcs_n, auxromcs_n, en245_n;
   logic ras_n, mux, cas1_n, cas2_n;
   integer seed;
   integer r;
   integer i;
   integer j;
   integer cycles = 0;

   mioc_top mioc_top_i (.*);

   initial begin
      b_phi = 1'b0;
      forever #5 b_phi = ~b_phi;
   end

   // about 41 cycles of 8 clocks plus reset is near 340, so 500 leaves margin
   always @(posedge b_phi) begin
      cycles <= cycles + 1;
      if (mioc_top_i.mioc_properties_i.err_seen) begin
         $display("ERRORS FOUND");
         $fatal(1, "an assertion in the property checker fired");
      end else if (cycles >= 500) begin
         $display("ERRORS FOUND");
         $fatal(1, "timeout after %0d cycles, the stimulus did not finish", cycles);
      end
   end

   // all strobes back to inactive, then two idle clocks before the next cycle
   task automatic bus_idle();
      bmreq_n <= 1'b1;
      iorq_n  <= 1'b1;
      brd_n   <= 1'b1;
      bwr_n   <= 1'b1;
      brfsh_n <= 1'b1;
      repeat (2) @(posedge b_phi);
   endtask

   // one memory read, write or refresh, held for six clocks
   task automatic mem_cycle(input logic [2:0] hi, input logic refresh, input logic write);
      {ba15, ba14, ba13} <= hi;
      bmreq_n <= 1'b0;
      brfsh_n <= !refresh;
      brd_n   <= refresh || write;   // a refresh cycle carries no read strobe
      bwr_n   <= refresh || !write;
      repeat (6) @(posedge b_phi);
      bus_idle();
   endtask

   // I/O write, aimed at the map port when hit is set and one port away otherwise
   task automatic map_write(input logic [3:0] value, input logic hit);
      iorq_n <= 1'b0;
      bwr_n  <= 1'b0;
      ba7    <= hit ? `MIOC_MAP_PORT_A7 : !`MIOC_MAP_PORT_A7;
      ba6    <= `MIOC_MAP_PORT_A6;
      {bd3, bd2, bd1, bd0} <= value;
      repeat (6) @(posedge b_phi);
      bus_idle();
   endtask

   task automatic random_access();
      integer v;
      v = $random(seed);
      mem_cycle(v[2:0], v[5:3] == 3'd0, v[6]);   // one in eight is a refresh
   endtask

   task automatic button_pulse();
      pbrst_n <= 1'b0;
      repeat (2) @(posedge b_phi);
      pbrst_n <= 1'b1;
      repeat (2) @(posedge b_phi);
   endtask

   initial begin
      rst     = 1'b1;
      {ba15, ba14, ba13, ba7, ba6} = 5'b0;
      {bd3, bd2, bd1, bd0} = 4'h0;
      {iorq_n, bmreq_n, bwr_n, brd_n, brfsh_n} = 5'b11111;
      pbrst_n = 1'b1;
      seed    = 32'h571e_73df;
      repeat (2) @(posedge b_phi);
      rst <= 1'b0;
      for (i = 0; i < 8; i++) begin
         mem_cycle(i[2:0], 1'b0, 1'b0);   // the whole address space under map zero
      end
      for (i = 0; i < 4; i++) begin
         r = $random(seed);
         map_write(r[3:0], r[5:4] != 2'b00);
         for (j = 0; j < 6; j++) begin
            random_access();
         end
      end
      mem_cycle(3'd2, 1'b1, 1'b0);
      map_write(4'he, 1'b1);              // cartridge high, expansion ROM low
      button_pulse();
      mem_cycle(3'd0, 1'b0, 1'b0);        // boot ROM is back at the bottom
      mem_cycle(3'd7, 1'b0, 1'b1);        // and RAM at the top
      random_access();
      random_access();
      repeat (3) @(posedge b_phi);
      if (mioc_top_i.mioc_properties_i.err_seen) begin
         $display("ERRORS FOUND");
         $fatal(1, "an assertion fired in the last cycles");
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

// ==== flist.f ====
+incdir+hw
hw/mioc_pkg.sv
hw/bus_cycle_if.sv
hw/bus_sampler.sv
hw/memory_map_reg.sv
hw/memory_decoder.sv
hw/dram_sequencer.sv
hw/mioc_top.sv
tests/mioc_properties.sv
tests/mioc_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory and I/O controller testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module mioc_tb \
		-f flist.f --Mdir $(OBJ_DIR) -o mioc_tb

# a failed check ends in $fatal, which gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/mioc_tb +verilator+error+limit+10

clean:
	rm -rf $(OBJ_DIR)
